//--- config_pkg.sv
// Issue block configuration

package config_pkg;

  // ========================================
  // Configuration record
  // ========================================

  // Sizing of one issue block instance
  typedef struct packed {
    // Number of reservation station entries
    int RS_DEPTH;
    // Operand data width
    int XLEN;
    // Dispatch lanes per cycle as fixed by the frontend
    int DISPATCH_W;
  } cfg_t;

  // 8 entries, 32-bit operands, 4 lanes
  localparam cfg_t DefaultCfg = '{
    RS_DEPTH:   8,
    XLEN:       32,
    DISPATCH_W: 4
  };

  // ========================================
  // Bus defaults
  // ========================================

  // Physical register tag width
  localparam int TAG_W_DEF = 6;
  // Number of CDB broadcast ports
  localparam int CDB_W_DEF = 2;

endpackage

//--- decode_pkg.sv
// Micro-op and issue payload types

package decode_pkg;

  // Widest operand and tag the structs can carry
  localparam int DATA_MAX = 32;
  localparam int TAG_MAX  = 6;

  // ========================================
  // Micro-op
  // ========================================

  // Passed to the FU untouched
  typedef struct packed {
    logic [6:0] opcode;
    logic [3:0] funct;
    logic [4:0] imm_sel;
  } uop_t;

  // One dispatch lane and the stored entry payload
  typedef struct packed {
    uop_t                uop;
    logic [TAG_MAX-1:0]  dst;
    // Src1
    logic [DATA_MAX-1:0] v1;
    logic [TAG_MAX-1:0]  q1;
    logic                r1;
    // Src2
    logic [DATA_MAX-1:0] v2;
    logic [TAG_MAX-1:0]  q2;
    logic                r2;
  } dispatch_t;

  // Reservation station slot
  typedef struct packed {
    logic      busy;
    dispatch_t payload;
  } rs_entry_t;

  // One CDB broadcast port valid for a single cycle
  typedef struct packed {
    logic                valid;
    logic [TAG_MAX-1:0]  tag;
    logic [DATA_MAX-1:0] value;
  } cdb_t;

  // ========================================
  // FU payload
  // ========================================

  typedef struct packed {
    uop_t                uop;
    logic [DATA_MAX-1:0] v1;
    logic [DATA_MAX-1:0] v2;
    logic [TAG_MAX-1:0]  dst;
  } issue_t;

endpackage

//--- rs_allocator.sv
// Reservation station allocator
`timescale 1ns/100ps

module rs_allocator #(
  parameter int RS_DEPTH = 8,
  parameter int DATA_W   = 32,
  parameter int TAG_W    = 6
) (
  input  logic [RS_DEPTH-1:0]            busy_vector,
  input  logic [3:0]                     dispatch_valid,
  input  decode_pkg::dispatch_t          dispatch_lane [4],
  output logic [RS_DEPTH-1:0]            entry_wen,
  output decode_pkg::dispatch_t          routed_entries [RS_DEPTH],
  output logic                           issue_ready,
  output logic [$clog2(RS_DEPTH+1)-1:0]  free_count
);
  import decode_pkg::*;

  localparam int CNT_W = $clog2(RS_DEPTH + 1);

  // Position of each valid lane and each free entry in its own order
  int unsigned lane_rank [4];
  int unsigned free_rank [RS_DEPTH];
  int unsigned lane_total;
  int unsigned free_total;
  logic        group_fits;

  // Drop bits above the configured data and tag widths
  function automatic dispatch_t clip_lane(input dispatch_t d);
    dispatch_t c;
    c     = d;
    c.dst = TAG_MAX'(d.dst[TAG_W-1:0]);
    c.v1  = DATA_MAX'(d.v1[DATA_W-1:0]);
    c.q1  = TAG_MAX'(d.q1[TAG_W-1:0]);
    c.v2  = DATA_MAX'(d.v2[DATA_W-1:0]);
    c.q2  = TAG_MAX'(d.q2[TAG_W-1:0]);
    return c;
  endfunction

  always_comb begin
    lane_total = 0;
    for (int i = 0; i < 4; i++) begin
      lane_rank[i] = lane_total;
      if (dispatch_valid[i]) lane_total++;
    end
    free_total = 0;
    for (int e = 0; e < RS_DEPTH; e++) begin
      free_rank[e] = free_total;
      if (!busy_vector[e]) free_total++;
    end
  end

  // Whole group or nothing
  assign group_fits  = (free_total >= lane_total);
  assign issue_ready = group_fits;
  assign free_count  = CNT_W'(free_total);

  // n-th valid lane lands in the n-th lowest free entry
  always_comb begin
    for (int e = 0; e < RS_DEPTH; e++) begin
      entry_wen[e]      = 1'b0;
      routed_entries[e] = '0;
      if (!busy_vector[e]) begin
        for (int i = 0; i < 4; i++) begin
          if (dispatch_valid[i] && lane_rank[i] == free_rank[e]) begin
            entry_wen[e]      = group_fits;
            routed_entries[e] = clip_lane(dispatch_lane[i]);
          end
        end
      end
    end
  end

endmodule

//--- reservation_station.sv
// Reservation station with CDB wakeup
`timescale 1ns/100ps

module reservation_station #(
  parameter int RS_DEPTH = 8,
  parameter int DATA_W   = 32,
  parameter int TAG_W    = 6,
  parameter int CDB_W    = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic [RS_DEPTH-1:0]   entry_wen,
  input  decode_pkg::dispatch_t routed_entries [RS_DEPTH],
  input  decode_pkg::cdb_t      cdb [CDB_W],
  input  logic [RS_DEPTH-1:0]   grant_onehot,
  output logic [RS_DEPTH-1:0]   busy_vector,
  output logic [RS_DEPTH-1:0]   ready_mask,
  output decode_pkg::issue_t    sel_entry
);
  import decode_pkg::*;

  // ========================================
  // Storage
  // ========================================

  rs_entry_t entry_q [RS_DEPTH];

  // Payload after this cycle's CDB snoop
  dispatch_t woke [RS_DEPTH];

  // Capture any CDB value whose tag matches a waiting source
  function automatic dispatch_t wake(input dispatch_t d, input cdb_t port [CDB_W]);
    dispatch_t w;
    w = d;
    for (int c = 0; c < CDB_W; c++) begin
      if (port[c].valid) begin
        if (!w.r1 && w.q1[TAG_W-1:0] == port[c].tag[TAG_W-1:0]) begin
          w.v1 = DATA_MAX'(port[c].value[DATA_W-1:0]);
          w.r1 = 1'b1;
        end
        if (!w.r2 && w.q2[TAG_W-1:0] == port[c].tag[TAG_W-1:0]) begin
          w.v2 = DATA_MAX'(port[c].value[DATA_W-1:0]);
          w.r2 = 1'b1;
        end
      end
    end
    return w;
  endfunction

  // New writes snoop the same edge's broadcast as stored entries
  always_comb begin
    for (int e = 0; e < RS_DEPTH; e++) begin
      if (entry_wen[e]) begin
        woke[e] = wake(routed_entries[e], cdb);
      end else begin
        woke[e] = wake(entry_q[e].payload, cdb);
      end
    end
  end

  // ========================================
  // Entry update
  // ========================================

  always_ff @(posedge clk) begin
    for (int e = 0; e < RS_DEPTH; e++) begin
      entry_q[e].payload <= woke[e];
      if (!rst_n || flush) begin
        entry_q[e].busy <= 1'b0;
      end else if (entry_wen[e]) begin
        entry_q[e].busy <= 1'b1;
      end else if (grant_onehot[e]) begin
        // Issued this edge and free from the next cycle
        entry_q[e].busy <= 1'b0;
      end
    end
  end

  // ========================================
  // Status and read port
  // ========================================

  // Wakeup reaches the mask one cycle after the broadcast
  always_comb begin
    for (int e = 0; e < RS_DEPTH; e++) begin
      busy_vector[e] = entry_q[e].busy;
      ready_mask[e]  = entry_q[e].busy && entry_q[e].payload.r1 && entry_q[e].payload.r2;
    end
  end

  // One-hot mux of the granted entry
  always_comb begin
    sel_entry = '0;
    for (int e = 0; e < RS_DEPTH; e++) begin
      if (grant_onehot[e]) begin
        sel_entry.uop = entry_q[e].payload.uop;
        sel_entry.v1  = entry_q[e].payload.v1;
        sel_entry.v2  = entry_q[e].payload.v2;
        sel_entry.dst = entry_q[e].payload.dst;
      end
    end
  end

endmodule

//--- issue_select.sv
// Single-issue select and FU register
`timescale 1ns/100ps

module issue_select #(
  parameter int RS_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  logic [RS_DEPTH-1:0] ready_mask,
  input  decode_pkg::issue_t  sel_entry,
  output logic [RS_DEPTH-1:0] grant_onehot,
  output logic                fu_en,
  output decode_pkg::issue_t  fu_issue
);

  logic any_ready;

  // ========================================
  // Priority pick
  // ========================================

  // Lowest set bit of the ready mask
  assign grant_onehot = ready_mask & (~ready_mask + RS_DEPTH'(1));
  assign any_ready    = |ready_mask;

  // ========================================
  // FU output register
  // ========================================

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      fu_en <= 1'b0;
    end else begin
      fu_en <= any_ready;
    end
  end

  // Granted payload toward the FU
  always_ff @(posedge clk) begin
    fu_issue <= sel_entry;
  end

endmodule

//--- issue_single.sv
// Single-issue reservation station block
`timescale 1ns/100ps

module issue_single #(
  parameter config_pkg::cfg_t Cfg = config_pkg::DefaultCfg,
  parameter int RS_DEPTH = Cfg.RS_DEPTH,
  parameter int DATA_W   = Cfg.XLEN,
  parameter int TAG_W    = config_pkg::TAG_W_DEF,
  parameter int CDB_W    = config_pkg::CDB_W_DEF
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,

  // Dispatch
  input  logic [Cfg.DISPATCH_W-1:0]      dispatch_valid,
  input  decode_pkg::dispatch_t          dispatch_lane [Cfg.DISPATCH_W],
  output logic                           issue_ready,
  output logic [$clog2(RS_DEPTH+1)-1:0]  free_count,

  // Result broadcast
  input  decode_pkg::cdb_t               cdb [CDB_W],

  // FU port
  output logic                           fu_en,
  output decode_pkg::issue_t             fu_issue
);
  import decode_pkg::*;

  // Allocator and station
  logic [RS_DEPTH-1:0] busy_vector;
  logic [RS_DEPTH-1:0] entry_wen;
  dispatch_t           routed_entries [RS_DEPTH];

  // Station and selector
  logic [RS_DEPTH-1:0] ready_mask;
  logic [RS_DEPTH-1:0] grant_onehot;
  issue_t              sel_entry;

  // ========================================
  // Input side
  // ========================================

  rs_allocator #(
    .RS_DEPTH (RS_DEPTH),
    .DATA_W   (DATA_W),
    .TAG_W    (TAG_W)
  ) u_alloc (
    .busy_vector    (busy_vector),
    .dispatch_valid (dispatch_valid),
    .dispatch_lane  (dispatch_lane),
    .entry_wen      (entry_wen),
    .routed_entries (routed_entries),
    .issue_ready    (issue_ready),
    .free_count     (free_count)
  );

  // ========================================
  // Station
  // ========================================

  reservation_station #(
    .RS_DEPTH (RS_DEPTH),
    .DATA_W   (DATA_W),
    .TAG_W    (TAG_W),
    .CDB_W    (CDB_W)
  ) u_rs (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .entry_wen      (entry_wen),
    .routed_entries (routed_entries),
    .cdb            (cdb),
    .grant_onehot   (grant_onehot),
    .busy_vector    (busy_vector),
    .ready_mask     (ready_mask),
    .sel_entry      (sel_entry)
  );

  // Output side
  issue_select #(
    .RS_DEPTH (RS_DEPTH)
  ) u_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .ready_mask   (ready_mask),
    .sel_entry    (sel_entry),
    .grant_onehot (grant_onehot),
    .fu_en        (fu_en),
    .fu_issue     (fu_issue)
  );

endmodule

//--- issue_single_sva.sv
// Issue block handshake assertions
`timescale 1ns/100ps

module issue_single_sva #(
  parameter int RS_DEPTH = 8
) (
  input logic                clk,
  input logic                rst_n,
  input logic                flush,
  input logic                fu_en,
  input logic                issue_ready,
  input logic [3:0]          dispatch_valid,
  input logic [RS_DEPTH-1:0] entry_wen,
  input logic [RS_DEPTH-1:0] grant_onehot
);

  int fail_count = 0;

  // FU output dropped after a flush
  assert property (@(posedge clk) disable iff (!rst_n) flush |=> !fu_en)
    else begin
      $error("fu_en high in the cycle after a flush");
      fail_count++;
    end

  // Writes only for an accepted group with one entry per valid lane
  assert property (@(posedge clk) disable iff (!rst_n)
    (|entry_wen) |-> (issue_ready && $countones(entry_wen) == $countones(dispatch_valid)))
    else begin
      $error("entry writes do not match an accepted dispatch group");
      fail_count++;
    end

  // Issued entry is released at once
  assert property (@(posedge clk) disable iff (!rst_n)
    (|grant_onehot) |=> ((grant_onehot & $past(grant_onehot)) == '0))
    else begin
      $error("same entry granted on two cycles in a row");
      fail_count++;
    end

endmodule

bind issue_single issue_single_sva #(.RS_DEPTH(RS_DEPTH)) u_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .flush          (flush),
  .fu_en          (fu_en),
  .issue_ready    (issue_ready),
  .dispatch_valid (dispatch_valid),
  .entry_wen      (entry_wen),
  .grant_onehot   (grant_onehot)
);

//--- tb_issue_model.svh
// Reservation station reference model
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

dispatch_t m_pl [RS_DEPTH];
logic      m_busy [RS_DEPTH];
logic      m_fu_en = 1'b0;
issue_t    m_fu_issue;

// Fill waiting sources from this edge's broadcast
function automatic dispatch_t wake_sources(input dispatch_t d);
  dispatch_t w;
  w = d;
  for (int p = 0; p < CDB_W; p++) begin
    if (cdb[p].valid && !w.r1 && w.q1 == cdb[p].tag) begin
      w.v1 = cdb[p].value;
      w.r1 = 1'b1;
    end
    if (cdb[p].valid && !w.r2 && w.q2 == cdb[p].tag) begin
      w.v2 = cdb[p].value;
      w.r2 = 1'b1;
    end
  end
  return w;
endfunction

function automatic int count_free();
  int n;
  n = 0;
  for (int e = 0; e < RS_DEPTH; e++) begin
    if (!m_busy[e]) n++;
  end
  return n;
endfunction

// One clock edge with consumed low when the dispatch group is held
task automatic step_model(output logic consumed);
  int free_list [RS_DEPTH];
  int nfree;
  int k;
  int g;
  nfree = 0;
  g     = -1;
  for (int e = 0; e < RS_DEPTH; e++) begin
    if (!m_busy[e]) begin
      free_list[nfree] = e;
      nfree++;
    end
    if (g < 0 && m_busy[e] && m_pl[e].r1 && m_pl[e].r2) g = e;
  end
  consumed = !rst_n || flush || ($countones(dispatch_valid) <= nfree);
  m_fu_en  = rst_n && !flush && (g >= 0);
  if (g >= 0) begin
    m_fu_issue = '{uop: m_pl[g].uop, v1: m_pl[g].v1, v2: m_pl[g].v2, dst: m_pl[g].dst};
  end
  for (int e = 0; e < RS_DEPTH; e++) begin
    m_pl[e] = wake_sources(m_pl[e]);
    if (!rst_n || flush || e == g) m_busy[e] = 1'b0;
  end
  // Lanes in order onto the lowest free entries
  if (rst_n && !flush && consumed) begin
    k = 0;
    for (int i = 0; i < 4; i++) begin
      if (dispatch_valid[i]) begin
        m_pl[free_list[k]]   = wake_sources(dispatch_lane[i]);
        m_busy[free_list[k]] = 1'b1;
        k++;
      end
    end
  end
endtask

`endif

//--- tb_issue_single.sv
// Issue block testbench
`timescale 1ns/100ps

module tb_issue_single;
  import config_pkg::*;
  import decode_pkg::*;

  localparam int RS_DEPTH  = DefaultCfg.RS_DEPTH;
  localparam int CDB_W     = CDB_W_DEF;
  localparam int RESET_CYC = 8;
  // Reset followed by the six tests in order
  localparam int TOTAL_CYC = RESET_CYC + 4 + 40 + 120 + 120 + 42 + 1500;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       flush;
  logic [3:0] dispatch_valid;
  dispatch_t  dispatch_lane [4];
  cdb_t       cdb [CDB_W];
  logic       issue_ready;
  logic [$clog2(RS_DEPTH+1)-1:0] free_count;
  logic       fu_en;
  issue_t     fu_issue;

  logic [31:0] lfsr = 32'h2bcf_5d51;
  logic [63:0] tag_pend = '0;
  logic [31:0] tag_val [64];
  // Probabilities out of 256
  int unsigned p_lane;
  int unsigned p_wait;
  int unsigned p_cdb;
  int unsigned p_flush;
  logic        force_flush = 1'b0;
  int          cyc = 0;
  int          n_err = 0;
  int          err_mark = 0;
  int          n_checks = 0;
  string       test_name;

  issue_single #(.Cfg(DefaultCfg)) dut0 (.*);

  `include "tb_issue_model.svh"

  always #20 clk = ~clk;

  // Watchdog
  initial begin
    #(TOTAL_CYC * 40 * 2);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Waiting source tag that becomes an outstanding producer
  function automatic logic [5:0] pick_tag();
    logic [5:0] t;
    t = 6'(rand_bits(6));
    if (!tag_pend[t]) begin
      tag_pend[t] = 1'b1;
      tag_val[t]  = rand_bits(32);
    end
    return t;
  endfunction

  function automatic dispatch_t make_lane();
    dispatch_t d;
    d     = '0;
    d.uop = 16'(rand_bits(16));
    d.dst = 6'(rand_bits(6));
    d.r1  = rand_bits(8) >= p_wait;
    if (d.r1) d.v1 = rand_bits(32);
    else d.q1 = pick_tag();
    d.r2  = rand_bits(8) >= p_wait;
    if (d.r2) d.v2 = rand_bits(32);
    else d.q2 = pick_tag();
    return d;
  endfunction

  task automatic gen_inputs(input logic consumed);
    logic [3:0] v;
    cdb_t       c [CDB_W];
    logic [5:0] start;
    logic [5:0] idx;
    if (consumed) begin
      for (int i = 0; i < 4; i++) begin
        v[i] = rand_bits(8) < p_lane;
        dispatch_lane[i] <= make_lane();
      end
      dispatch_valid <= v;
    end else begin
      // Held group keeps its producers outstanding
      for (int i = 0; i < 4; i++) begin
        if (dispatch_valid[i] && !dispatch_lane[i].r1) tag_pend[dispatch_lane[i].q1] = 1'b1;
        if (dispatch_valid[i] && !dispatch_lane[i].r2) tag_pend[dispatch_lane[i].q2] = 1'b1;
      end
    end
    for (int p = 0; p < CDB_W; p++) begin
      c[p] = '0;
      if (rand_bits(8) < p_cdb) begin
        start = 6'(rand_bits(6));
        for (int t = 0; t < 64; t++) begin
          idx = start + 6'(t);
          if (tag_pend[idx] && !c[p].valid) begin
            c[p]          = '{valid: 1'b1, tag: idx, value: tag_val[idx]};
            tag_pend[idx] = 1'b0;
          end
        end
      end
    end
    cdb   <= c;
    flush <= force_flush || (rand_bits(8) < p_flush);
    rst_n <= cyc >= RESET_CYC;
  endtask

  task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
    n_checks++;
    assert (exp == act) else begin
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      n_err++;
    end
  endtask

  task automatic run_cycles(input int n);
    logic consumed;
    repeat (n) begin
      @(posedge clk);
      cyc++;
      step_model(consumed);
      gen_inputs(consumed);
      // Outputs settled mid-cycle
      @(negedge clk);
      check("free_count", 128'(count_free()), 128'(free_count));
      check("issue_ready", 128'(count_free() >= $countones(dispatch_valid)), 128'(issue_ready));
      check("fu_en", 128'(m_fu_en), 128'(fu_en));
      if (m_fu_en && fu_en) check("fu_issue", 128'(m_fu_issue), 128'(fu_issue));
    end
  endtask

  task automatic run_test(input string name, input int n);
    test_name = name;
    run_cycles(n);
    $display("test %s errors %0d  %s", name, n_err - err_mark,
             (n_err == err_mark) ? "ok" : "failed");
    err_mark = n_err;
  endtask

  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch_valid = '0;
    for (int i = 0; i < 4; i++) dispatch_lane[i] = '0;
    for (int p = 0; p < CDB_W; p++) cdb[p] = '0;
    for (int t = 0; t < 64; t++) tag_val[t] = '0;
    p_lane  = 0;
    p_wait  = 0;
    p_cdb   = 0;
    p_flush = 0;

    test_name = "reset";
    run_cycles(RESET_CYC);
    check("free_count", 128'(RS_DEPTH), 128'(free_count));
    check("issue_ready", 128'(1'b1), 128'(issue_ready));
    check("fu_en", 128'(1'b0), 128'(fu_en));
    run_test("reset", 4);

    p_lane = 100;
    run_test("ready_issue", 40);

    p_lane = 60;
    p_wait = 160;
    p_cdb  = 100;
    run_test("wakeup", 120);

    // Ready sources only while leftover producers drain
    p_lane = 230;
    p_wait = 0;
    run_test("back_pressure", 120);

    // Entries left waiting on tags that are not broadcast
    p_lane = 150;
    p_wait = 250;
    p_cdb  = 0;
    test_name = "flush";
    run_cycles(10);
    force_flush = 1'b1;
    run_cycles(1);
    force_flush = 1'b0;
    p_lane = 0;
    run_cycles(1);
    check("free_count", 128'(RS_DEPTH), 128'(free_count));
    p_cdb = 200;
    run_test("flush", 30);

    p_lane  = 90;
    p_wait  = 100;
    p_cdb   = 140;
    p_flush = 3;
    run_test("random_mix", 1500);

    n_err += dut0.u_sva.fail_count;
    $display("Checks %0d, errors %0d", n_checks, n_err);
    if (n_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
config_pkg.sv
decode_pkg.sv
rs_allocator.sv
reservation_station.sv
issue_select.sv
issue_single.sv
issue_single_sva.sv
tb_issue_single.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_issue_single -f filelist.f -o sim_tb
	out=$$(./obj_dir/sim_tb); echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
